// ==== cache_flush_pkg.sv ====
package cache_flush_pkg;

    localparam int index_width = 6;
    localparam int num_sets    = 64;
    // 0..128 dirty ways, so one bit more than the way count would suggest
    localparam int count_width = index_width + 2;

    localparam logic [3:0] addr_line_op = 4'h0;
    localparam logic [3:0] addr_ctrl    = 4'h4;
    localparam logic [3:0] addr_status  = 4'h8;
    localparam logic [3:0] addr_lookup  = 4'hC;

    // read word layout
    localparam int status_busy_bit  = 31;    // count sits in the low bits
    localparam int lookup_index_lsb = 8;     // dirty bits in [1:0]

    typedef struct packed {
        logic [22:0]            pad;
        logic [index_width-1:0] index;
        logic                   dirty;       // value written to masked ways
        logic [1:0]             way_mask;
    } line_op_t;

    typedef struct packed {
        logic [30:0] pad;
        logic        start;
    } ctrl_op_t;

    // one write word, read as line op or ctrl op by address
    typedef union packed {
        line_op_t line;
        ctrl_op_t ctrl;
    } apb_cmd_u;

    typedef struct packed {
        logic [index_width-1:0] index;
        logic [1:0]             ways;        // dirty ways of that set
    } set_hit_t;

    typedef struct packed {
        logic [index_width-1:0] index;
        logic                   way;
    } wb_req_t;

    typedef struct packed {
        logic                   en;
        logic [1:0]             way_mask;
        logic                   dirty;
        logic [index_width-1:0] index;
    } dt_write_t;

endpackage

// ==== dirty_table.sv ====
`timescale 1ns/100ps

module dirty_table import cache_flush_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  dt_write_t              wr,
    input  logic [index_width-1:0] lookup_index,
    output logic [1:0]             lookup_bits,
    input  logic [index_width-1:0] scan_index,
    output logic [1:0]             scan_bits,
    input  logic                   clr_valid,
    input  logic [index_width-1:0] clr_index,
    input  logic                   clr_way,
    output logic [count_width-1:0] dirty_count
);

    logic [1:0]             dirty_q [num_sets];
    logic [1:0]             wr_old;
    logic [1:0]             wr_new;
    logic [1:0]             ones_old;
    logic [1:0]             ones_new;
    logic                   clr_hit;
    logic [count_width-1:0] count_next;

    function automatic logic [1:0] ones2(input logic [1:0] v);
        return {1'b0, v[0]} + {1'b0, v[1]};
    endfunction

    assign lookup_bits = dirty_q[lookup_index];
    assign scan_bits   = dirty_q[scan_index];   // same-cycle read for the scanner

    always_comb begin
        wr_old   = dirty_q[wr.index];
        wr_new   = (wr_old & ~wr.way_mask) | (wr.way_mask & {2{wr.dirty}});
        ones_old = ones2(wr_old);
        ones_new = ones2(wr_new);
        clr_hit  = clr_valid && dirty_q[clr_index][clr_way];   // only a set bit counts

        // count follows real bit changes, -2..+2 per software write
        count_next = dirty_count;
        if (wr.en) begin
            count_next = count_next + count_width'(ones_new) - count_width'(ones_old);
        end
        if (clr_hit) begin
            count_next = count_next - 1'b1;
        end
    end

    // software writes are blocked while flushing, so they never meet a clear
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < num_sets; i++) begin
                dirty_q[i] <= 2'b00;
            end
            dirty_count <= '0;
        end else begin
            if (wr.en) begin
                dirty_q[wr.index] <= wr_new;
            end
            if (clr_hit) begin
                dirty_q[clr_index][clr_way] <= 1'b0;
            end
            dirty_count <= count_next;
        end
    end

endmodule

// ==== flush_scan.sv ====
`timescale 1ns/100ps

module flush_scan import cache_flush_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush_start,
    output logic                   busy,
    output logic                   flush_done,
    output logic [index_width-1:0] scan_index,
    input  logic [1:0]             scan_bits,
    output logic                   hit_valid,
    output set_hit_t               hit,
    input  logic                   hit_ready,
    input  logic                   stage_empty
);

    logic [index_width-1:0] set_cnt;
    logic                   scan_end;    // last set inspected
    logic                   scanning;
    logic                   out_free;
    logic                   step;
    logic                   done_cond;

    assign scan_index = set_cnt;
    assign scanning   = busy && !scan_end;
    assign out_free   = !hit_valid || hit_ready;   // stall on a held hit
    assign step       = scanning && out_free;
    assign done_cond  = busy && scan_end && !hit_valid && stage_empty;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy       <= 1'b0;
            flush_done <= 1'b0;
            scan_end   <= 1'b0;
            set_cnt    <= '0;
            hit_valid  <= 1'b0;
        end else begin
            flush_done <= done_cond;   // busy drops at the same edge
            if (flush_start && !busy) begin
                busy     <= 1'b1;
                scan_end <= 1'b0;
                set_cnt  <= '0;
            end else if (done_cond) begin
                busy <= 1'b0;
            end
            if (hit_valid && hit_ready) begin
                hit_valid <= 1'b0;
            end
            if (step) begin
                if (|scan_bits) begin
                    hit_valid <= 1'b1;
                end
                set_cnt <= set_cnt + 1'b1;
                if (set_cnt == index_width'(num_sets - 1)) begin
                    scan_end <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step && |scan_bits) begin
            hit.index <= set_cnt;
            hit.ways  <= scan_bits;
        end
    end

endmodule

// ==== wb_issue.sv ====
`timescale 1ns/100ps

module wb_issue import cache_flush_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   hit_valid,
    input  set_hit_t               hit,
    output logic                   hit_ready,
    output logic                   stage_empty,
    output logic                   wb_valid,
    output wb_req_t                wb_req,
    input  logic                   wb_ready,
    output logic                   clr_valid,
    output logic [index_width-1:0] clr_index,
    output logic                   clr_way
);

    logic [index_width-1:0] set_q;
    logic [1:0]             ways_q;     // ways still to write back
    logic                   cur_way;
    logic                   take;
    logic                   accept;

    assign stage_empty = (ways_q == 2'b00);
    assign hit_ready   = stage_empty;
    assign take        = hit_valid && hit_ready;

    // lowest remaining way, way 0 first
    assign cur_way = !ways_q[0];

    assign wb_valid     = !stage_empty;
    assign wb_req.index = set_q;
    assign wb_req.way   = cur_way;
    assign accept       = wb_valid && wb_ready;

    assign clr_valid = accept;     // clear the way on the accepting cycle
    assign clr_index = set_q;
    assign clr_way   = cur_way;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ways_q <= 2'b00;
        end else if (take) begin
            ways_q <= hit.ways;
        end else if (accept) begin
            ways_q[cur_way] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            set_q <= hit.index;
        end
    end

endmodule

// ==== apb_regs.sv ====
`timescale 1ns/100ps

module apb_regs import cache_flush_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [3:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pslverr,
    output dt_write_t              wr,
    output logic [index_width-1:0] lookup_index,
    input  logic [1:0]             lookup_bits,
    input  logic [count_width-1:0] dirty_count,
    input  logic                   busy,
    output logic                   flush_start
);

    apb_cmd_u    cmd;
    logic        access;
    logic        wr_access;
    logic        known_addr;
    logic        busy_reject;
    logic [31:0] status_word;
    logic [31:0] lookup_word;

    assign cmd       = pwdata;
    assign access    = psel && penable;     // no wait states, pready is always high
    assign wr_access = access && pwrite;

    always_comb begin
        case (paddr)
            addr_line_op, addr_ctrl, addr_status, addr_lookup: known_addr = 1'b1;
            default: known_addr = 1'b0;
        endcase
    end

    // table changes are refused while a flush runs
    assign busy_reject = pwrite && busy && (paddr == addr_line_op || paddr == addr_ctrl);
    assign pslverr     = access && (!known_addr || busy_reject);

    always_comb begin
        wr.en       = wr_access && (paddr == addr_line_op) && !busy;
        wr.way_mask = cmd.line.way_mask;
        wr.dirty    = cmd.line.dirty;
        wr.index    = cmd.line.index;
    end

    assign flush_start = wr_access && (paddr == addr_ctrl) && cmd.ctrl.start && !busy;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lookup_index <= '0;
        end else if (wr_access && paddr == addr_lookup) begin
            lookup_index <= pwdata[index_width-1:0];
        end
    end

    // read mux, current state in the access cycle
    always_comb begin
        status_word                                     = '0;
        status_word[count_width-1:0]                    = dirty_count;
        status_word[status_busy_bit]                    = busy;
        lookup_word                                     = '0;
        lookup_word[1:0]                                = lookup_bits;
        lookup_word[lookup_index_lsb +: index_width]    = lookup_index;
        case (paddr)
            addr_ctrl:   prdata = {31'b0, busy};
            addr_status: prdata = status_word;
            addr_lookup: prdata = lookup_word;
            default:     prdata = '0;     // line op is write only
        endcase
    end

endmodule

// ==== cache_flush_top.sv ====
`timescale 1ns/100ps

module cache_flush_top import cache_flush_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    output logic        wb_valid,
    output wb_req_t     wb_req,
    input  logic        wb_ready,
    output logic        flush_done
);

    dt_write_t              wr;
    logic [index_width-1:0] lookup_index;
    logic [1:0]             lookup_bits;
    logic [count_width-1:0] dirty_count;
    logic                   busy;
    logic                   flush_start;
    logic [index_width-1:0] scan_index;
    logic [1:0]             scan_bits;
    logic                   hit_valid;
    set_hit_t               hit;
    logic                   hit_ready;
    logic                   stage_empty;
    logic                   clr_valid;
    logic [index_width-1:0] clr_index;
    logic                   clr_way;

    apb_regs u_regs (.*);

    dirty_table u_table (.*);

    flush_scan u_scan (.*);     // stage 1, walks the sets

    wb_issue u_issue (.*);      // stage 2, one request per dirty way

endmodule

// ==== cache_flush_assertions.sv ====
`timescale 1ns/100ps

module cache_flush_assertions import cache_flush_pkg::*; (
    input logic    clk,
    input logic    rstn,
    input logic    psel,
    input logic    penable,
    input logic    pslverr,
    input logic    busy,
    input logic    wb_valid,
    input logic    wb_ready,
    input wb_req_t wb_req,
    input logic    flush_done
);

    int fail_cnt = 0;   // summed into the final result

    // request held until memory takes it
    wb_hold: assert property (@(posedge clk) disable iff (!rstn)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_req))
        else begin
            fail_cnt++;
            $error("wb_req changed or wb_valid dropped before wb_ready");
        end

    err_in_access: assert property (@(posedge clk) disable iff (!rstn)
        pslverr |-> psel && penable)
        else begin
            fail_cnt++;
            $error("pslverr outside an APB access cycle");
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        flush_done |=> !flush_done)
        else begin
            fail_cnt++;
            $error("flush_done high for more than one cycle");
        end

    // no writeback outside a flush
    idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
        !busy |-> !wb_valid)
        else begin
            fail_cnt++;
            $error("wb_valid high while the flush is idle");
        end

endmodule

// ==== tb_cache_flush.sv ====
`timescale 1ns/100ps

module tb_cache_flush import cache_flush_pkg::*; ();

    localparam int n_ops         = 40;
    localparam int op_cycles     = 12 * n_ops;       // write, lookup pair, status
    localparam int flush_cycles  = 2 * (num_sets + 4 * 2 * num_sets);   // stalls at most double
    localparam int verify_cycles = 6 * num_sets + 3;
    localparam int run_cycles    = 3 * op_cycles + 4 * (flush_cycles + verify_cycles) + 30;

    logic        clk = 1'b0;
    logic        rstn, psel, penable, pwrite, wb_ready;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr, wb_valid, flush_done;
    wb_req_t     wb_req;

    logic [31:0] lfsr = 32'h9f3b29b8;
    logic [1:0]  model [num_sets];     // expected dirty bits per set
    wb_req_t     seen [$];
    int          valid_cycles = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;

    cache_flush_top dut0 (.*);

    bind cache_flush_top cache_flush_assertions u_assert (.*);

    always #50 clk = ~clk;

    // accepted writebacks, taken before the edge moves the state
    always @(posedge clk) begin
        if (rstn && wb_valid) begin
            valid_cycles++;
            if (wb_ready) begin
                seen.push_back(wb_req);
            end
        end
    end

    function automatic logic [31:0] next_rand(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic apb_xfer(input logic [3:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #25;                   // late in the access cycle
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        check_cnt++;
        assert (act_v === exp_v) else begin
            $display("mismatch %s expected %h actual %h", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input logic ok, input string what);
        check_cnt++;
        assert (ok) else begin
            $display("%s", what);
            err_cnt++;
        end
    endtask

    task automatic check_set(input int s);
        logic [31:0] rd;
        logic        err;
        apb_xfer(addr_lookup, 1'b1, 32'(s), rd, err);
        apb_xfer(addr_lookup, 1'b0, '0, rd, err);
        check_val("lookup", (32'(s) << lookup_index_lsb) | 32'(model[s]), rd);
    endtask

    task automatic check_count();
        logic [31:0] rd;
        logic        err;
        int          cnt;
        cnt = 0;
        for (int s = 0; s < num_sets; s++) begin
            cnt += model[s][0] + model[s][1];
        end
        apb_xfer(addr_status, 1'b0, '0, rd, err);
        check_val("status", 32'(cnt), rd);      // busy bit low when idle
    endtask

    task automatic line_ops(input int n);
        logic [31:0]            rd;
        logic                   err;
        logic [index_width-1:0] s;
        logic [1:0]             mask;
        logic                   d;
        for (int i = 0; i < n; i++) begin
            s    = index_width'(next_rand(index_width));
            mask = 2'(next_rand(2));
            d    = next_rand(2) != 0;           // mostly marks
            apb_xfer(addr_line_op, 1'b1, {23'b0, s, d, mask}, rd, err);
            check_val("pslverr", 32'(0), 32'(err));
            for (int w = 0; w < 2; w++) begin
                if (mask[w]) begin
                    model[s][w] = d;
                end
            end
            check_set(s);
            check_count();
        end
    endtask

    task automatic run_flush(input logic stall, input logic started);
        logic [31:0] rd;
        logic        err;
        logic        done;
        int          cyc;
        wb_req_t     exp_q [$];
        seen.delete();
        valid_cycles = 0;
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (model[s][w]) begin
                    exp_q.push_back({index_width'(s), 1'(w)});   // ascending, way 0 first
                end
            end
        end
        if (!started) begin
            apb_xfer(addr_ctrl, 1'b1, 32'h1, rd, err);
        end
        cyc = 0;
        do begin
            @(negedge clk);
            wb_ready = stall ? (next_rand(1) != 0) : 1'b1;
            #25;
            done = flush_done;
            cyc++;
        end while (!done && cyc < flush_cycles);
        @(negedge clk);
        wb_ready = 1'b1;
        check_flag(done, "flush_done did not arrive within the flush time limit");
        check_val("writeback count", exp_q.size(), seen.size());
        for (int i = 0; i < exp_q.size() && i < seen.size(); i++) begin
            check_val("wb_req", 32'(exp_q[i]), 32'(seen[i]));
        end
        for (int s = 0; s < num_sets; s++) begin
            model[s] = 2'b00;
        end
        check_count();
        for (int s = 0; s < num_sets; s++) begin
            check_set(s);
        end
    endtask

    initial begin
        int                     first;
        int                     fails;
        logic [31:0]            rd;
        logic                   err;
        logic [index_width-1:0] s;
        rstn     = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        wb_ready = 1'b1;
        for (int i = 0; i < num_sets; i++) begin
            model[i] = 2'b00;
        end
        repeat (10) @(negedge clk);
        rstn = 1'b1;

        first = err_cnt;
        line_ops(n_ops);
        $display("test 1 (line ops and lookups): %0d errors", err_cnt - first);

        first = err_cnt;
        run_flush(1'b0, 1'b0);
        $display("test 2 (flush of random table): %0d errors", err_cnt - first);

        first = err_cnt;
        line_ops(n_ops);
        run_flush(1'b1, 1'b0);
        $display("test 3 (flush with wb_ready stalls): %0d errors", err_cnt - first);

        // table writes refused while the flush is held by wb_ready
        first = err_cnt;
        line_ops(n_ops);
        wb_ready = 1'b0;
        apb_xfer(addr_ctrl, 1'b1, 32'h1, rd, err);
        apb_xfer(addr_status, 1'b0, '0, rd, err);
        check_flag(rd[status_busy_bit], "status busy bit low during a flush");
        s = index_width'(next_rand(index_width));
        apb_xfer(addr_line_op, 1'b1, {23'b0, s, ~model[s][0], 2'b11}, rd, err);
        check_flag(err, "no pslverr on a line op write during a flush");
        check_set(s);                  // dropped write leaves the set as it was
        apb_xfer(addr_ctrl, 1'b1, 32'h1, rd, err);
        check_flag(err, "no pslverr on a ctrl write during a flush");
        run_flush(1'b0, 1'b1);
        apb_xfer(4'h6, 1'b0, '0, rd, err);
        check_flag(err, "no pslverr on an unknown address");
        $display("test 4 (pslverr cases): %0d errors", err_cnt - first);

        first = err_cnt;
        run_flush(1'b0, 1'b0);
        check_flag(valid_cycles == 0, "wb_valid raised while flushing an empty table");
        $display("test 5 (empty table flush): %0d errors", err_cnt - first);

        fails = err_cnt + dut0.u_assert.fail_cnt;
        $display("5 tests, %0d checks, %0d check errors, %0d assertion failures",
                 check_cnt, err_cnt, dut0.u_assert.fail_cnt);
        if (fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog with a margin over the worst case run length
    initial begin
        #(2 * run_cycles * 100);
        $display("run exceeded its time limit");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== sim.f ====
cache_flush_pkg.sv
dirty_table.sv
flush_scan.sv
wb_issue.sv
apb_regs.sv
cache_flush_top.sv
cache_flush_assertions.sv
tb_cache_flush.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_cache_flush -o tb_cache_flush \
    && ./obj_dir/tb_cache_flush +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || grep -q ">>> PASS" sim.log
